// ==== Bender.yml ====
package:
  name: flight_cmd

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/flight_pkg.sv
      - hdl/flight_mode.sv
      - hdl/rec_data_buffer.sv
      - hdl/motor_mixer.sv
      - hdl/flight_cmd_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/flight_cmd_checker.sv
      - verif/flight_cmd_tb.sv

// ==== hdl/flight_cmd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flight_params.svh"

module flight_cmd_top
  import flight_pkg::*;
(
  input  logic       us_clk,
  input  logic       rst,
  input  rc_cmd_t    rc,
  input  logic       swa,
  input  logic       swb,
  output rc_cmd_t    setpoint,
  output motor_cmd_t motors,
  output rec_sel_e   mode
);

  // ramp status back to the selector, and the running throttle back to the ramp
  logic                            takeoff_done;
  logic [`PWM_VALUE_BIT_WIDTH-1:0] curr_motor_rate;

  // the registered mode is both the buffer select and the mode seen outside
  flight_mode u_flight_mode (
    .us_clk       (us_clk),
    .rst          (rst),
    .swa          (swa),
    .swb          (swb),
    .takeoff_done (takeoff_done),
    .rec_data_sel (mode)
  );

  // setpoint goes out to the angle controller and on to the mixer
  rec_data_buffer u_rec_data_buffer (
    .us_clk          (us_clk),
    .rst             (rst),
    .rec_data_sel    (mode),
    .rc              (rc),
    .curr_motor_rate (curr_motor_rate),
    .setpoint        (setpoint),
    .takeoff_done    (takeoff_done)
  );

  motor_mixer u_motor_mixer (
    .us_clk          (us_clk),
    .rst             (rst),
    .setpoint        (setpoint),
    .motors          (motors),
    .curr_motor_rate (curr_motor_rate)
  );

endmodule

`default_nettype wire

// ==== hdl/flight_mode.sv ====
`timescale 1ns/1ps
`default_nettype none

module flight_mode
  import flight_pkg::*;
(
  input  logic     us_clk,
  input  logic     rst,
  input  logic     swa,
  input  logic     swb,
  input  logic     takeoff_done,
  output rec_sel_e rec_data_sel
);

  rec_sel_e mode_next;

  // next mode from the two switches and the ramp status
  // swa acts as the arm switch, so dropping it always returns to off
  always_comb begin
    mode_next = rec_data_sel;
    if (!swa) begin
      mode_next = SEL_OFF;
    end else begin
      case (rec_data_sel)
        // armed with swb low flies the sticks directly
        // raising swb as well starts an automatic takeoff
        SEL_OFF, SEL_PASS_THROUGH: begin
          if (swb) begin
            mode_next = SEL_AUTO_TAKE_OFF;
          end else begin
            mode_next = SEL_PASS_THROUGH;
          end
        end
        // swb was high to get here, so seeing it low means it fell
        SEL_AUTO_TAKE_OFF: begin
          if (!swb) begin
            mode_next = SEL_AUTO_LAND;
          end else if (takeoff_done) begin
            mode_next = SEL_HOVER;
          end
        end
        SEL_HOVER: begin
          if (!swb) begin
            mode_next = SEL_AUTO_LAND;
          end
        end
        // auto-land is only left through the swa check above
        SEL_AUTO_LAND: begin
          mode_next = SEL_AUTO_LAND;
        end
        // an encoding outside the five codes is treated like a restart
        default: begin
          mode_next = SEL_OFF;
        end
      endcase
    end
  end

  always_ff @(posedge us_clk) begin
    if (rst) begin
      rec_data_sel <= SEL_OFF;
    end else begin
      rec_data_sel <= mode_next;
    end
  end

  // the select register never holds anything but the five known codes
  assert property (@(posedge us_clk) disable iff (rst)
    rec_data_sel inside {SEL_OFF, SEL_AUTO_TAKE_OFF, SEL_HOVER, SEL_PASS_THROUGH,
                         SEL_AUTO_LAND})
    else $error("flight_mode: illegal select code %0h", rec_data_sel);

endmodule

`default_nettype wire

// ==== hdl/flight_pkg.sv ====
`default_nettype none

`include "flight_params.svh"

package flight_pkg;

  // what the setpoint buffer forwards toward the angle controller
  // the encodings are shared with the select codes in the params header
  typedef enum logic [`REC_SEL_BIT_WIDTH-1:0] {
    SEL_OFF           = `REC_SEL_BIT_WIDTH'(`REC_SEL_OFF),
    SEL_AUTO_TAKE_OFF = `REC_SEL_BIT_WIDTH'(`REC_SEL_AUTO_TAKE_OFF),
    SEL_HOVER         = `REC_SEL_BIT_WIDTH'(`REC_SEL_HOVER),
    SEL_PASS_THROUGH  = `REC_SEL_BIT_WIDTH'(`REC_SEL_PASS_THROUGH),
    SEL_AUTO_LAND     = `REC_SEL_BIT_WIDTH'(`REC_SEL_AUTO_LAND)
  } rec_sel_e;

  // one set of stick values, used for the receiver input and the buffered setpoint
  // throttle is unsigned while yaw, roll and pitch are signed offsets around zero
  typedef struct packed {
    logic [`PWM_VALUE_BIT_WIDTH-1:0] yaw;
    logic [`PWM_VALUE_BIT_WIDTH-1:0] roll;
    logic [`PWM_VALUE_BIT_WIDTH-1:0] pitch;
    logic [`PWM_VALUE_BIT_WIDTH-1:0] throttle;
  } rc_cmd_t;

  // unsigned rates for the four rotors of the quad
  typedef struct packed {
    logic [`PWM_VALUE_BIT_WIDTH-1:0] front_left;
    logic [`PWM_VALUE_BIT_WIDTH-1:0] front_right;
    logic [`PWM_VALUE_BIT_WIDTH-1:0] rear_left;
    logic [`PWM_VALUE_BIT_WIDTH-1:0] rear_right;
  } motor_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/motor_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flight_params.svh"

module motor_mixer
  import flight_pkg::*;
(
  input  logic                            us_clk,
  input  logic                            rst,
  input  rc_cmd_t                         setpoint,
  output motor_cmd_t                      motors,
  output logic [`PWM_VALUE_BIT_WIDTH-1:0] curr_motor_rate
);

  localparam int W = `PWM_VALUE_BIT_WIDTH;
  // three extra bits hold the sum of throttle and three quarter-scale corrections
  localparam int SUM_W = W + 3;

  logic signed [SUM_W-1:0] thr_w;
  logic signed [SUM_W-1:0] pitch_q;
  logic signed [SUM_W-1:0] roll_q;
  logic signed [SUM_W-1:0] yaw_q;
  logic signed [SUM_W-1:0] fl_sum;
  logic signed [SUM_W-1:0] fr_sum;
  logic signed [SUM_W-1:0] rl_sum;
  logic signed [SUM_W-1:0] rr_sum;
  logic                    motors_off;

  // limits a wide signed sum to the legal motor range
  function automatic logic [W-1:0] clamp_motor(input logic signed [SUM_W-1:0] sum);
    if (sum < 0) begin
      return '0;
    end else if (sum > SUM_W'(`MOTOR_VAL_MAX)) begin
      return W'(`MOTOR_VAL_MAX);
    end else begin
      return sum[W-1:0];
    end
  endfunction

  // attitude terms are sign extended first and then scaled down by four
  assign thr_w   = $signed({3'b000, setpoint.throttle});
  assign pitch_q = $signed({{3{setpoint.pitch[W-1]}}, setpoint.pitch}) >>> 2;
  assign roll_q  = $signed({{3{setpoint.roll[W-1]}}, setpoint.roll}) >>> 2;
  assign yaw_q   = $signed({{3{setpoint.yaw[W-1]}}, setpoint.yaw}) >>> 2;

  // positive pitch speeds the rear pair, positive roll the left pair
  // diagonal pairs share a spin direction, so yaw pushes one diagonal against the other
  assign fl_sum = thr_w - pitch_q + roll_q - yaw_q;
  assign fr_sum = thr_w - pitch_q - roll_q + yaw_q;
  assign rl_sum = thr_w + pitch_q + roll_q + yaw_q;
  assign rr_sum = thr_w + pitch_q - roll_q - yaw_q;

  // a throttle too low to lift keeps every rotor still whatever the sticks say
  assign motors_off = setpoint.throttle < W'(`MOTOR_VAL_MIN);

  always_ff @(posedge us_clk) begin
    if (rst) begin
      motors          <= '0;
      curr_motor_rate <= '0;
    end else begin
      curr_motor_rate <= setpoint.throttle;
      if (motors_off) begin
        motors <= '0;
      end else begin
        motors.front_left  <= clamp_motor(fl_sum);
        motors.front_right <= clamp_motor(fr_sum);
        motors.rear_left   <= clamp_motor(rl_sum);
        motors.rear_right  <= clamp_motor(rr_sum);
      end
    end
  end

  assert property (@(posedge us_clk) disable iff (rst)
    motors.front_left <= W'(`MOTOR_VAL_MAX) && motors.front_right <= W'(`MOTOR_VAL_MAX) &&
    motors.rear_left <= W'(`MOTOR_VAL_MAX) && motors.rear_right <= W'(`MOTOR_VAL_MAX))
    else $error("motor_mixer: motor rate above limit in %0h", motors);

endmodule

`default_nettype wire

// ==== hdl/rec_data_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flight_params.svh"

module rec_data_buffer
  import flight_pkg::*;
(
  input  logic                            us_clk,
  input  logic                            rst,
  input  rec_sel_e                        rec_data_sel,
  input  rc_cmd_t                         rc,
  input  logic [`PWM_VALUE_BIT_WIDTH-1:0] curr_motor_rate,
  output rc_cmd_t                         setpoint,
  output logic                            takeoff_done
);

  localparam int W = `PWM_VALUE_BIT_WIDTH;
  localparam int TW = `TAKE_OFF_TIMER_BIT_WIDTH;

  // level flight at hover throttle, attitude held level
  localparam rc_cmd_t HOVER_CMD = '{
    yaw:      '0,
    roll:     '0,
    pitch:    '0,
    throttle: W'(`HOVER_THROTTLE_VAL)
  };

  logic [TW-1:0] ramp_timer;
  logic [TW-1:0] stage_load;
  // one bit wider so a high motor rate cannot wrap back into the ramp
  logic [W:0]    ramp_step;
  logic          ramp_active;

  // the stage follows the throttle now on the bus and each stage steps at its own pace
  always_comb begin
    ramp_step   = {1'b0, curr_motor_rate} + 1'b1;
    ramp_active = setpoint.throttle < W'(`TAKEOFF_RAMP_THROTTLE_VAL_3);
    if (setpoint.throttle < W'(`TAKEOFF_RAMP_THROTTLE_VAL_1)) begin
      stage_load = TW'(`TAKE_OFF_TIMER_1);
    end else if (setpoint.throttle < W'(`TAKEOFF_RAMP_THROTTLE_VAL_2)) begin
      stage_load = TW'(`TAKE_OFF_TIMER_2);
    end else begin
      stage_load = TW'(`TAKE_OFF_TIMER_3);
    end
  end

  always_ff @(posedge us_clk) begin
    if (rst) begin
      setpoint     <= '0;
      takeoff_done <= 1'b0;
      ramp_timer   <= '0;
    end else begin
      // the done flag and the timer only live while a takeoff is running
      takeoff_done <= 1'b0;
      ramp_timer   <= '0;
      case (rec_data_sel)
        // auto-land has no height sensor yet and flies the sticks like pass-through
        SEL_PASS_THROUGH, SEL_AUTO_LAND: begin
          setpoint <= rc;
        end
        SEL_HOVER: begin
          setpoint <= HOVER_CMD;
        end
        SEL_AUTO_TAKE_OFF: begin
          // attitude stays level for the whole climb
          setpoint.yaw   <= '0;
          setpoint.roll  <= '0;
          setpoint.pitch <= '0;
          if (!ramp_active) begin
            setpoint.throttle <= W'(`HOVER_THROTTLE_VAL);
            takeoff_done      <= 1'b1;
          end else if (ramp_timer == '0) begin
            // step one above what the mixer is actually running at
            // reaching the last limit finishes the takeoff on the same edge
            if (ramp_step >= (W + 1)'(`TAKEOFF_RAMP_THROTTLE_VAL_3)) begin
              setpoint.throttle <= W'(`HOVER_THROTTLE_VAL);
              takeoff_done      <= 1'b1;
            end else begin
              setpoint.throttle <= ramp_step[W-1:0];
            end
            ramp_timer <= stage_load;
          end else begin
            ramp_timer <= ramp_timer - 1'b1;
          end
        end
        // off, and any code that should not occur, park everything at zero
        default: begin
          setpoint <= '0;
        end
      endcase
    end
  end

  // a disarmed controller always hands zero to the angle loop one cycle later
  assert property (@(posedge us_clk) disable iff (rst)
    rec_data_sel == SEL_OFF |=> setpoint == '0)
    else $error("rec_data_buffer: setpoint %0h not cleared after off", setpoint);

endmodule

`default_nettype wire

// ==== include/flight_params.svh ====
`ifndef FLIGHT_PARAMS_SVH
`define FLIGHT_PARAMS_SVH

// width of every stick, setpoint and motor value
`define PWM_VALUE_BIT_WIDTH 8

// width of the select code between the mode selector and the setpoint buffer
`define REC_SEL_BIT_WIDTH 4

// select codes seen by the setpoint buffer
`define REC_SEL_OFF 0
`define REC_SEL_AUTO_TAKE_OFF 1
`define REC_SEL_HOVER 2
`define REC_SEL_PASS_THROUGH 3
`define REC_SEL_AUTO_LAND 4

// throttle limits that end each of the three takeoff ramp stages
`define TAKEOFF_RAMP_THROTTLE_VAL_1 115
`define TAKEOFF_RAMP_THROTTLE_VAL_2 165
`define TAKEOFF_RAMP_THROTTLE_VAL_3 185

// us_clk cycles between ramp steps, per stage
// flight hardware loads counts in the thousands and these short ones keep a full ramp brief
`define TAKE_OFF_TIMER_BIT_WIDTH 17
`define TAKE_OFF_TIMER_1 6
`define TAKE_OFF_TIMER_2 3
`define TAKE_OFF_TIMER_3 8

// throttle held once the ramp completes and while hovering
`define HOVER_THROTTLE_VAL 185

// below this throttle every motor is stopped
`define MOTOR_VAL_MIN 10
// no motor rate goes above this
`define MOTOR_VAL_MAX 250

`endif

// ==== src.f ====
+incdir+include
hdl/flight_pkg.sv
hdl/flight_mode.sv
hdl/rec_data_buffer.sv
hdl/motor_mixer.sv
hdl/flight_cmd_top.sv
verif/flight_cmd_checker.sv
verif/flight_cmd_tb.sv

// ==== verif/flight_cmd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flight_params.svh"

module flight_cmd_checker
  import flight_pkg::*;
(
  input  logic       us_clk,
  input  logic       rst,
  input  rc_cmd_t    rc,
  input  logic       swa,
  input  logic       swb,
  input  rc_cmd_t    setpoint,
  input  motor_cmd_t motors,
  input  rec_sel_e   mode,
  input  int         test_num,
  output int         errors
);

  // reference state with one register per pipeline stage of the DUT
  rec_sel_e   m_mode;
  rc_cmd_t    m_sp;
  motor_cmd_t m_motors;
  logic [7:0] m_rate;
  logic       m_done;
  int         m_timer;

  // bookkeeping for the per-test lines and the ramp checks
  int         test_errors;
  int         cur_test;
  int         cycle;
  rec_sel_e   mode_d1;
  rec_sel_e   mode_d2;
  int         prev_thr;
  int         step_from;
  int         step_cycle;

  // swa low disarms and swb picks between sticks and takeoff
  function automatic rec_sel_e mode_rule(input rec_sel_e cur, input logic a, input logic b,
                                         input logic done);
    if (!a) return SEL_OFF;
    case (cur)
      SEL_OFF, SEL_PASS_THROUGH: begin
        if (b) return SEL_AUTO_TAKE_OFF;
        return SEL_PASS_THROUGH;
      end
      SEL_AUTO_TAKE_OFF: begin
        if (!b) return SEL_AUTO_LAND;
        if (done) return SEL_HOVER;
        return SEL_AUTO_TAKE_OFF;
      end
      SEL_HOVER: begin
        if (!b) return SEL_AUTO_LAND;
        return SEL_HOVER;
      end
      // only auto-land is left, and it holds until swa drops
      default: return SEL_AUTO_LAND;
    endcase
  endfunction

  // cycles the ramp waits after a step taken from this throttle
  function automatic int timer_load(input int thr);
    if (thr < `TAKEOFF_RAMP_THROTTLE_VAL_1) return `TAKE_OFF_TIMER_1;
    if (thr < `TAKEOFF_RAMP_THROTTLE_VAL_2) return `TAKE_OFF_TIMER_2;
    return `TAKE_OFF_TIMER_3;
  endfunction

  // signed stick offset scaled down by four, rounding toward minus infinity
  function automatic int quarter(input logic [7:0] v);
    int s;
    s = int'($signed(v));
    return s >>> 2;
  endfunction

  function automatic logic [7:0] clamp_rate(input int v);
    if (v < 0) return 8'd0;
    if (v > `MOTOR_VAL_MAX) return 8'(`MOTOR_VAL_MAX);
    return 8'(v);
  endfunction

  // in the quad-X mixing table every motor gets the throttle plus three signed corrections
  function automatic motor_cmd_t mix(input rc_cmd_t sp);
    motor_cmd_t m;
    int thr;
    int p;
    int r;
    int y;
    thr = int'(sp.throttle);
    p = quarter(sp.pitch);
    r = quarter(sp.roll);
    y = quarter(sp.yaw);
    m = '0;
    if (thr >= `MOTOR_VAL_MIN) begin
      m.front_left  = clamp_rate(thr - p + r - y);
      m.front_right = clamp_rate(thr - p - r + y);
      m.rear_left   = clamp_rate(thr + p + r + y);
      m.rear_right  = clamp_rate(thr + p - r - y);
    end
    return m;
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %s: expected 0x%h, actual 0x%h", name, exp, act);
    errors++;
    test_errors++;
  endtask

  task automatic report_fault(input string what);
    $display("ramp fault at cycle %0d: %s", cycle, what);
    errors++;
    test_errors++;
  endtask

  // the reference moves on the same edges as the DUT and every stage updates from its old value
  always @(posedge us_clk) begin : model
    rc_cmd_t sp_n;
    logic    done_n;
    int      timer_n;
    int      thr;
    int      step;
    if (rst) begin
      m_mode   <= SEL_OFF;
      m_sp     <= '0;
      m_motors <= '0;
      m_rate   <= '0;
      m_done   <= 1'b0;
      m_timer  <= 0;
    end else begin
      sp_n = '0;
      done_n = 1'b0;
      timer_n = 0;
      thr = int'(m_sp.throttle);
      step = int'(m_rate) + 1;
      case (m_mode)
        SEL_PASS_THROUGH, SEL_AUTO_LAND: sp_n = rc;
        SEL_HOVER: sp_n.throttle = 8'(`HOVER_THROTTLE_VAL);
        SEL_AUTO_TAKE_OFF: begin
          sp_n.throttle = m_sp.throttle;
          if (thr >= `TAKEOFF_RAMP_THROTTLE_VAL_3) begin
            sp_n.throttle = 8'(`HOVER_THROTTLE_VAL);
            done_n = 1'b1;
          end else if (m_timer == 0) begin
            timer_n = timer_load(thr);
            if (step >= `TAKEOFF_RAMP_THROTTLE_VAL_3) begin
              sp_n.throttle = 8'(`HOVER_THROTTLE_VAL);
              done_n = 1'b1;
            end else begin
              sp_n.throttle = 8'(step);
            end
          end else begin
            timer_n = m_timer - 1;
          end
        end
        default: sp_n = '0;
      endcase
      m_mode   <= mode_rule(m_mode, swa, swb, m_done);
      m_sp     <= sp_n;
      m_done   <= done_n;
      m_timer  <= timer_n;
      m_rate   <= m_sp.throttle;
      m_motors <= mix(m_sp);
    end
  end

  // the falling edge sits half a period away from every register update
  always @(negedge us_clk) begin
    if (rst) begin
      errors = 0;
      test_errors = 0;
      cur_test = 0;
      cycle = 0;
      mode_d1 = SEL_OFF;
      mode_d2 = SEL_OFF;
      prev_thr = 0;
      step_from = 0;
      step_cycle = 0;
    end else begin
      cycle++;
      if (mode !== m_mode) report_value("mode", 32'(m_mode), 32'(mode));
      if (setpoint !== m_sp) report_value("setpoint", m_sp, setpoint);
      if (motors !== m_motors) report_value("motors", m_motors, motors);
      // the setpoint seen now was produced under the mode seen one cycle earlier
      if (mode_d1 == SEL_AUTO_TAKE_OFF) begin
        if (mode_d2 != SEL_AUTO_TAKE_OFF) begin
          step_from = prev_thr;
          step_cycle = cycle;
        end else if (int'(setpoint.throttle) != prev_thr) begin
          if (int'(setpoint.throttle) < prev_thr) begin
            report_fault($sformatf("throttle fell from %0d to %0d", prev_thr,
                                   setpoint.throttle));
          end else if (cycle - step_cycle != timer_load(step_from) + 1) begin
            report_fault($sformatf("step to %0d came %0d cycles after the last one, not %0d",
                                   setpoint.throttle, cycle - step_cycle,
                                   timer_load(step_from) + 1));
          end
          step_from = prev_thr;
          step_cycle = cycle;
        end
      end
      mode_d2 = mode_d1;
      mode_d1 = mode;
      prev_thr = int'(setpoint.throttle);
      // a new entry index from the stimulus loop closes the previous test
      if (test_num != cur_test) begin
        if (test_errors == 0) $display("test %0d passed", cur_test);
        else $display("test %0d failed with %0d errors", cur_test, test_errors);
        cur_test = test_num;
        test_errors = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/flight_cmd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flight_params.svh"

module flight_cmd_tb
  import flight_pkg::*;
();

  // one stimulus row holds the switch levels, the stick word and how long to hold them
  // fresh_rc draws new sticks every cycle
  // to_hover first waits for the hover mode
  typedef struct packed {
    logic        swa;
    logic        swb;
    logic        fresh_rc;
    logic        to_hover;
    rc_cmd_t     rc;
    logic [15:0] hold;
  } entry_t;

  logic       us_clk = 1'b0;
  logic       rst;
  rc_cmd_t    rc;
  logic       swa;
  logic       swb;
  rc_cmd_t    setpoint;
  motor_cmd_t motors;
  rec_sel_e   mode;
  int         test_num;
  int         errors;
  entry_t     stim_table[$];
  logic [31:0] rng_state = 32'h6735_9034;
  int         cycle_count = 0;
  int         run_limit = 100000;

  always #5 us_clk = ~us_clk;

  flight_cmd_top uut (
    .us_clk   (us_clk),
    .rst      (rst),
    .rc       (rc),
    .swa      (swa),
    .swb      (swb),
    .setpoint (setpoint),
    .motors   (motors),
    .mode     (mode)
  );

  flight_cmd_checker u_checker (
    .us_clk   (us_clk),
    .rst      (rst),
    .rc       (rc),
    .swa      (swa),
    .swb      (swb),
    .setpoint (setpoint),
    .motors   (motors),
    .mode     (mode),
    .test_num (test_num),
    .errors   (errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_rc(output rc_cmd_t value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  // spacing of ramp steps taken from a given throttle
  function automatic int step_gap(input int thr);
    if (thr < `TAKEOFF_RAMP_THROTTLE_VAL_1) return `TAKE_OFF_TIMER_1 + 1;
    if (thr < `TAKEOFF_RAMP_THROTTLE_VAL_2) return `TAKE_OFF_TIMER_2 + 1;
    return `TAKE_OFF_TIMER_3 + 1;
  endfunction

  // the longest climb takes one unit per step from zero throttle up to the last limit
  function automatic int ramp_length();
    int cycles;
    cycles = 0;
    for (int t = 0; t < `TAKEOFF_RAMP_THROTTLE_VAL_3; t++) cycles += step_gap(t);
    return cycles;
  endfunction

  task automatic add_entry(input logic a, input logic b, input logic fresh, input logic hover,
                           input rc_cmd_t value, input int hold);
    entry_t e;
    e.swa = a;
    e.swb = b;
    e.fresh_rc = fresh;
    e.to_hover = hover;
    e.rc = value;
    e.hold = 16'(hold);
    stim_table.push_back(e);
  endtask

  // fixed stick words are packed as yaw, roll, pitch, throttle
  task automatic build_table();
    rc_cmd_t r;
    draw_rc(r);
    add_entry(1'b0, 1'b0, 1'b1, 1'b0, r, 8);
    draw_rc(r);
    add_entry(1'b1, 1'b0, 1'b0, 1'b0, r, 6);
    add_entry(1'b1, 1'b0, 1'b0, 1'b0, {8'h00, 8'h00, 8'h7f, 8'd240}, 5);
    add_entry(1'b1, 1'b0, 1'b0, 1'b0, {8'h80, 8'h80, 8'h80, 8'd20}, 5);
    add_entry(1'b1, 1'b0, 1'b0, 1'b0, {8'h40, 8'hc0, 8'h7f, 8'd5}, 5);
    add_entry(1'b1, 1'b0, 1'b1, 1'b0, r, 20);
    add_entry(1'b0, 1'b0, 1'b0, 1'b0, r, 4);
    // full climb from zero throttle, then hover, auto-land and disarm
    add_entry(1'b1, 1'b1, 1'b0, 1'b1, r, 4);
    add_entry(1'b1, 1'b1, 1'b1, 1'b0, r, 20);
    add_entry(1'b1, 1'b0, 1'b1, 1'b0, r, 12);
    add_entry(1'b0, 1'b0, 1'b0, 1'b0, r, 6);
    // second climb cut short by swa
    add_entry(1'b1, 1'b1, 1'b0, 1'b0, r, 60);
    add_entry(1'b0, 1'b1, 1'b0, 1'b0, r, 8);
    add_entry(1'b1, 1'b0, 1'b1, 1'b0, r, 8);
    // climb started from the sticks, then swb drops it into auto-land
    add_entry(1'b1, 1'b1, 1'b0, 1'b0, {8'h10, 8'hf0, 8'h20, 8'd40}, 30);
    add_entry(1'b1, 1'b0, 1'b1, 1'b0, r, 10);
    add_entry(1'b0, 1'b0, 1'b0, 1'b0, r, 6);
  endtask

  always @(posedge us_clk) begin
    cycle_count++;
    if (cycle_count >= run_limit) begin
      $display("timeout: the run did not finish within %0d cycles", run_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin : main
    entry_t e;
    int     total_hold;
    rst = 1'b1;
    swa = 1'b0;
    swb = 1'b0;
    rc = '0;
    test_num = 0;
    build_table();
    total_hold = 0;
    foreach (stim_table[i]) total_hold += int'(stim_table[i].hold);
    run_limit = 3 + total_hold + 2 * ramp_length() + 20;
    repeat (3) @(posedge us_clk);
    #1;
    rst = 1'b0;
    foreach (stim_table[i]) begin
      e = stim_table[i];
      test_num = i;
      swa = e.swa;
      swb = e.swb;
      rc = e.rc;
      while (e.to_hover && mode != SEL_HOVER) begin
        @(posedge us_clk);
        #1;
      end
      repeat (e.hold) begin
        @(posedge us_clk);
        #1;
        if (e.fresh_rc) draw_rc(rc);
      end
    end
    // one more index lets the checker close the last test
    test_num = stim_table.size();
    repeat (2) @(posedge us_clk);
    $display("summary: %0d tests, %0d errors", stim_table.size(), errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
